// File: Bender.yml
package:
  name: elink_loop

sources:
  - files:
      - rtl/elink_pkg.sv
      - rtl/link_tx.sv
      - rtl/link_rx.sv
      - rtl/mem_target.sv
      - rtl/elink_loop.sv
  - target: test
    files:
      - test/elink_loop_assertions.sv
      - test/elink_loop_tb.sv

# Simulation top is elink_loop_tb, synthesis top is elink_loop
# Run from the project root so test/elink_loop_patterns.txt is found

// File: project.f
rtl/elink_pkg.sv
rtl/link_tx.sv
rtl/link_rx.sv
rtl/mem_target.sv
rtl/elink_loop.sv
test/elink_loop_assertions.sv
test/elink_loop_tb.sv

// File: rtl/elink_loop.sv
`timescale 1ns/1ns
`default_nettype none

module elink_loop (
   input  logic               clkin,
   input  logic               reset,
   input  logic               ext_valid,     // Request in
   input  elink_pkg::packet_t ext_packet,
   output logic               ext_ready,
   output logic               dut_valid,     // Read response out
   output elink_pkg::packet_t dut_packet,
   input  logic               dut_ready
);

   logic               fwd_frame;                // Forward link, toward memory
   logic [7:0]         fwd_data;
   logic               fwd_wait;

   logic               req_valid;                // Reassembled request
   logic               req_ready;
   elink_pkg::packet_t req_packet;

   logic               rsp_valid;                // Read response from memory
   logic               rsp_ready;
   elink_pkg::packet_t rsp_packet;

   logic               ret_frame;                // Return link, toward requester
   logic [7:0]         ret_data;
   logic               ret_wait;

   link_tx fwd_tx (
      .clkin      (clkin),
      .reset      (reset),
      .in_valid   (ext_valid),
      .in_packet  (ext_packet),
      .link_wait  (fwd_wait),
      .in_ready   (ext_ready),
      .link_frame (fwd_frame),
      .link_data  (fwd_data)
   );

   link_rx fwd_rx (
      .clkin      (clkin),
      .reset      (reset),
      .link_frame (fwd_frame),
      .link_data  (fwd_data),
      .out_ready  (req_ready),
      .link_wait  (fwd_wait),
      .out_valid  (req_valid),
      .out_packet (req_packet)
   );

   mem_target target (
      .clkin      (clkin),
      .reset      (reset),
      .req_valid  (req_valid),
      .req_packet (req_packet),
      .rsp_ready  (rsp_ready),
      .req_ready  (req_ready),
      .rsp_valid  (rsp_valid),
      .rsp_packet (rsp_packet)
   );

   link_tx ret_tx (
      .clkin      (clkin),
      .reset      (reset),
      .in_valid   (rsp_valid),
      .in_packet  (rsp_packet),
      .link_wait  (ret_wait),
      .in_ready   (rsp_ready),
      .link_frame (ret_frame),
      .link_data  (ret_data)
   );

   link_rx ret_rx (
      .clkin      (clkin),
      .reset      (reset),
      .link_frame (ret_frame),
      .link_data  (ret_data),
      .out_ready  (dut_ready),
      .link_wait  (ret_wait),
      .out_valid  (dut_valid),
      .out_packet (dut_packet)
   );

endmodule

`default_nettype wire

// File: rtl/elink_pkg.sv
`default_nettype none

package elink_pkg;

   localparam int PW         = 104;               // Packet width in bits
   localparam int LINK_BYTES = PW / 8;            // Bytes per packet on the link, 13
   localparam int BYTE_IDX_W = $clog2(LINK_BYTES); // Byte counter width

   // Index of the first byte on the wire, counts down to 0
   localparam logic [BYTE_IDX_W-1:0] LAST_BYTE = BYTE_IDX_W'(LINK_BYTES - 1);

   localparam logic [11:0] LINK_ID = 12'h820;     // Own chip ID of the remote link

   localparam int MEM_WORDS = 64;                 // Depth of remote memory
   localparam int MEM_AW    = $clog2(MEM_WORDS);  // Word address bits

   // Field layout, srcaddr on top, access at bit 0
   typedef struct packed {
      logic [31:0] srcaddr;                       // Bits 103:72
      logic [31:0] data;                          // Bits 71:40
      logic [31:0] dstaddr;                       // Bits 39:8
      logic [3:0]  ctrlmode;                      // Bits 7:4
      logic [1:0]  datamode;                      // Bits 3:2
      logic        write;                         // 1 write, 0 read
      logic        access;                        // Transaction marker
   } packet_fields_t;

   // Same 104-bit word seen as fields or as link bytes
   typedef union packed {
      packet_fields_t             fields;         // Decoded by memory target
      logic [LINK_BYTES-1:0][7:0] bytes;          // Byte 12 goes out first
   } packet_t;

endpackage

`default_nettype wire

// File: rtl/link_rx.sv
`timescale 1ns/1ns
`default_nettype none

module link_rx (
   input  logic               clkin,
   input  logic               reset,
   input  logic               link_frame,    // Byte present this cycle
   input  logic [7:0]         link_data,
   input  logic               out_ready,     // Consumer takes the packet
   output logic               link_wait,     // Back-pressure to transmitter
   output logic               out_valid,
   output elink_pkg::packet_t out_packet
);

   logic [elink_pkg::BYTE_IDX_W-1:0] idx_q;      // Slot for the next byte
   elink_pkg::packet_t               asm_q;      // Assembly register
   elink_pkg::packet_t               asm_next;   // Assembly with current byte
   elink_pkg::packet_t               hold_q;     // Complete packet
   logic                             hold_full_q; // Holding register occupied
   logic                             last_beat;  // Byte 0 arrives

   assign last_beat  = link_frame & (idx_q == '0);
   assign link_wait  = hold_full_q;              // Stops the link until drained
   assign out_valid  = hold_full_q;
   assign out_packet = hold_q;

   // Drop the incoming byte into its slot
   always_comb begin
      asm_next              = asm_q;
      asm_next.bytes[idx_q] = link_data;
   end

   // Byte counter and holding flag
   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         idx_q       <= elink_pkg::LAST_BYTE;
         hold_full_q <= 1'b0;
      end else begin
         if (last_beat) begin
            idx_q <= elink_pkg::LAST_BYTE;       // Next packet starts at MSB
         end else if (link_frame) begin
            idx_q <= idx_q - 1'b1;
         end
         if (last_beat) begin
            hold_full_q <= 1'b1;                 // Valid the cycle after byte 13
         end else if (out_ready) begin
            hold_full_q <= 1'b0;                 // Taken by consumer
         end
      end
   end

   // Payload path
   always_ff @(posedge clkin) begin
      if (link_frame) begin
         asm_q <= asm_next;
      end
      if (last_beat) begin
         hold_q <= asm_next;                     // Includes byte 0 of this cycle
      end
   end

endmodule

`default_nettype wire

// File: rtl/link_tx.sv
`timescale 1ns/1ns
`default_nettype none

module link_tx (
   input  logic               clkin,
   input  logic               reset,
   input  logic               in_valid,      // Packet offered
   input  elink_pkg::packet_t in_packet,
   input  logic               link_wait,     // Far end holding register full
   output logic               in_ready,      // Idle, can take a packet
   output logic               link_frame,    // Byte moves this cycle
   output logic [7:0]         link_data
);

   logic                               busy_q;   // Packet in flight
   logic [elink_pkg::BYTE_IDX_W-1:0]   idx_q;    // Byte now on the wire
   elink_pkg::packet_t                 pkt_q;    // Packet being sent
   logic                               accept;   // Handshake on input side
   logic                               last_beat; // Byte 0 goes out

   assign in_ready   = ~busy_q;                  // Free again after byte 0
   assign accept     = in_valid & in_ready;
   assign link_frame = busy_q & ~link_wait;      // Stall while far end is full
   assign link_data  = pkt_q.bytes[idx_q];       // MSB first
   assign last_beat  = link_frame & (idx_q == '0);

   // Busy flag and byte counter
   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         busy_q <= 1'b0;
         idx_q  <= elink_pkg::LAST_BYTE;
      end else begin
         if (accept) begin
            busy_q <= 1'b1;                      // Start at byte 12
         end else if (last_beat) begin
            busy_q <= 1'b0;                      // in_ready back next cycle
         end
         if (last_beat) begin
            idx_q <= elink_pkg::LAST_BYTE;       // Rewind for next packet
         end else if (link_frame) begin
            idx_q <= idx_q - 1'b1;               // Next lower byte
         end
      end
   end

   // Packet register, loaded only on accept
   always_ff @(posedge clkin) begin
      if (accept) begin
         pkt_q <= in_packet;
      end
   end

endmodule

`default_nettype wire

// File: rtl/mem_target.sv
`timescale 1ns/1ns
`default_nettype none

module mem_target (
   input  logic               clkin,
   input  logic               reset,
   input  logic               req_valid,     // Request from forward link
   input  elink_pkg::packet_t req_packet,
   input  logic               rsp_ready,     // Return link can take response
   output logic               req_ready,
   output logic               rsp_valid,     // Read response pending
   output elink_pkg::packet_t rsp_packet
);

   elink_pkg::packet_fields_t        req;        // Field view of request
   elink_pkg::packet_fields_t        rsp_next;   // Response being built
   logic [31:0]                      mem_q [elink_pkg::MEM_WORDS]; // Word store
   logic [elink_pkg::MEM_AW-1:0]     word_addr;  // From dstaddr 7:2
   logic                             filtered;   // Addressed to own chip ID
   logic                             accept;     // Request handshake
   logic                             wr_en;      // Store data word
   logic                             rd_en;      // Load response register
   logic                             rsp_full_q; // Response register occupied
   elink_pkg::packet_t               rsp_q;

   assign req       = req_packet.fields;
   assign word_addr = req.dstaddr[elink_pkg::MEM_AW+1:2];
   assign filtered  = (req.dstaddr[31:20] == elink_pkg::LINK_ID);

   // Writes and dropped packets always go, reads need an empty slot
   assign req_ready = filtered | req.write | ~rsp_full_q;
   assign accept    = req_valid & req_ready;
   assign wr_en     = accept & ~filtered & req.write;
   assign rd_en     = accept & ~filtered & ~req.write;

   assign rsp_valid  = rsp_full_q;
   assign rsp_packet = rsp_q;

   // Response swaps addresses and carries stored word
   always_comb begin
      rsp_next          = req;
      rsp_next.dstaddr  = req.srcaddr;           // Back to requester
      rsp_next.srcaddr  = req.dstaddr;
      rsp_next.data     = mem_q[word_addr];
      rsp_next.write    = 1'b1;                  // Responses travel as writes
      rsp_next.access   = 1'b1;
   end

   // Word memory, cleared on reset
   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < elink_pkg::MEM_WORDS; i++) begin
            mem_q[i] <= 32'h0;
         end
      end else if (wr_en) begin
         mem_q[word_addr] <= req.data;
      end
   end

   // Response register state
   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         rsp_full_q <= 1'b0;
      end else if (rd_en) begin
         rsp_full_q <= 1'b1;                     // Valid next cycle
      end else if (rsp_ready) begin
         rsp_full_q <= 1'b0;                    // Handed to return link
      end
   end

   // Response payload
   always_ff @(posedge clkin) begin
      if (rd_en) begin
         rsp_q.fields <= rsp_next;
      end
   end

endmodule

`default_nettype wire

// File: test/elink_loop_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module elink_loop_assertions (
   input logic               clkin,
   input logic               reset,
   input logic               dut_valid,
   input logic               dut_ready,
   input elink_pkg::packet_t dut_packet,
   input logic               fwd_frame,
   input logic               fwd_wait,
   input logic               ret_frame,
   input logic               ret_wait
);

   // Stalled response must not move or vanish
   property rsp_held_while_stalled;
      @(posedge clkin) disable iff (reset)
         (dut_valid && !dut_ready) |=> (dut_valid && $stable(dut_packet));
   endproperty

   property fwd_no_byte_on_wait;
      @(posedge clkin) disable iff (reset) !(fwd_frame && fwd_wait);
   endproperty

   property ret_no_byte_on_wait;
      @(posedge clkin) disable iff (reset) !(ret_frame && ret_wait);
   endproperty

   // Everything quiet under reset
   property quiet_in_reset;
      @(posedge clkin) reset |-> (!dut_valid && !fwd_frame && !ret_frame);
   endproperty

   assert property (rsp_held_while_stalled)
      else $error("dut_valid or dut_packet changed while dut_ready was low");
   assert property (fwd_no_byte_on_wait)
      else $error("Forward link framed a byte while its wait was high");
   assert property (ret_no_byte_on_wait)
      else $error("Return link framed a byte while its wait was high");
   assert property (quiet_in_reset)
      else $error("dut_valid or a link frame was high during reset");

endmodule

bind elink_loop elink_loop_assertions protocol_checks (
   .clkin      (clkin),
   .reset      (reset),
   .dut_valid  (dut_valid),
   .dut_ready  (dut_ready),
   .dut_packet (dut_packet),
   .fwd_frame  (fwd_frame),
   .fwd_wait   (fwd_wait),
   .ret_frame  (ret_frame),
   .ret_wait   (ret_wait)
);

`default_nettype wire

// File: test/elink_loop_patterns.txt
# name kind dstaddr data srcaddr expected, all numbers in hex
# kind W write, R read with expected read data, F filtered with the write bit in the last column
wr_w0      W 00000000 11111111 81000000 00000000
wr_w1      W 00000004 22222222 81000004 00000000
wr_w2      W 00000008 33333333 81000008 00000000
wr_w3      W 0000000c 44444444 8100000c 00000000
rd_w0      R 00000000 00000000 81000010 11111111
rd_w1      R 00000004 00000000 81000014 22222222
rd_w2      R 00000008 00000000 81000018 33333333
rd_w3      R 0000000c 00000000 8100001c 44444444
rd_fresh20 R 00000020 00000000 81000020 00000000
rd_fresh63 R 000000fc 00000000 81000024 00000000
wr_w4      W 00000010 55555555 81000028 00000000
flt_wr_w4  F 82000010 deadbeef 8100002c 00000001
rd_w4      R 00000010 00000000 81000030 55555555
flt_rd_w5  F 82000014 00000000 81000034 00000000
rd_w5      R 00000014 00000000 81000038 00000000
wr_near    W 82100018 66666666 8100003c 00000000
rd_near    R 00000018 00000000 81000040 66666666
flt_wr_w6  F 820fff18 77777777 81000044 00000001
rd_w6      R 00000018 00000000 81000048 66666666
wr_w0b     W 00000000 a5a5a5a5 8100004c 00000000
rd_w0b     R 00000000 00000000 81000050 a5a5a5a5
wr_b16     W 00000040 0badf00d 81000054 00000000
wr_b17     W 00000044 cafe0001 81000058 00000000
rd_b16     R 00000040 00000000 8100005c 0badf00d
rd_b17     R 00000044 00000000 81000060 cafe0001
rd_b16r    R 00000040 00000000 81000064 0badf00d
wr_b18     W 00000048 12345678 81000068 00000000
rd_b18     R 00000048 00000000 8100006c 12345678
flt_rd_b18 F 82000048 00000000 81000070 00000000
rd_b18r    R 00000048 00000000 81000074 12345678
rd_w1r     R 00000004 00000000 81000078 22222222
rd_w2r     R 00000008 00000000 8100007c 33333333
wr_top     W 000000fc fedcba98 81000080 00000000
rd_top     R 000000fc 00000000 81000084 fedcba98
rd_w3r     R 0000000c 00000000 81000088 44444444
rd_w4r     R 00000010 00000000 8100008c 55555555

// File: test/elink_loop_tb.sv
`timescale 1ns/1ns
`default_nettype none

module elink_loop_tb;

   localparam int          CLK_PERIOD      = 100;          // ns
   localparam int          RESET_CYCLES    = 4;
   localparam logic [31:0] SEED            = 32'h4c371a55;
   localparam int          CYCLES_PER_LINE = 80;           // Two link trips plus stalls
   localparam int          TIMEOUT_MARGIN  = 200;          // Reset, drain and slack
   localparam int          DRAIN_CYCLES    = 60;           // Quiet time for stray responses

   logic               clkin;
   logic               reset;
   logic               ext_valid;
   elink_pkg::packet_t ext_packet;
   logic               ext_ready;
   logic               dut_valid;
   elink_pkg::packet_t dut_packet;
   logic               dut_ready;

   elink_pkg::packet_t req_pkts [$];                      // Every request, file order
   elink_pkg::packet_t exp_pkts [$];                      // Responses of R lines only
   string              exp_names [$];
   int                 n_lines;
   int                 sent_cnt;                          // Requests accepted by DUT
   int                 rsp_cnt;                           // Responses taken from DUT
   int                 cycle_cnt;
   int                 cycle_limit;
   logic [31:0]        rng_state;
   logic [31:0]        rng_next;

   elink_loop dut (
      .clkin      (clkin),
      .reset      (reset),
      .ext_valid  (ext_valid),
      .ext_packet (ext_packet),
      .ext_ready  (ext_ready),
      .dut_valid  (dut_valid),
      .dut_packet (dut_packet),
      .dut_ready  (dut_ready)
   );

   initial begin
      clkin = 1'b0;
      forever #(CLK_PERIOD / 2) clkin = ~clkin;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;        // Numerical Recipes constants
   endfunction

   task automatic abort_run();
      $display(">>> FAIL");
      $fatal(1, "Simulation stopped on first error");
   endtask

   task automatic check_packet(input string name, input elink_pkg::packet_t expected,
                               input elink_pkg::packet_t actual);
      if (actual !== expected) begin
         $display("Error: test %s expected %h actual %h", name, expected, actual);
         abort_run();
      end
   endtask

   task automatic check_count(input string name, input int expected, input int actual);
      if (actual != expected) begin
         $display("Error: test %s expected %0d actual %0d", name, expected, actual);
         abort_run();
      end
   endtask

   // Builds request list and expected read responses
   task automatic read_patterns();
      int                        fd;
      int                        rc;
      string                     line;
      string                     name;
      string                     kind;
      logic [31:0]               dst;
      logic [31:0]               dat;
      logic [31:0]               src;
      logic [31:0]               expv;
      elink_pkg::packet_fields_t req;
      elink_pkg::packet_fields_t rsp;
      elink_pkg::packet_t        pkt;
      fd = $fopen("test/elink_loop_patterns.txt", "r");
      if (fd == 0) begin
         $display("Could not open the pattern file test/elink_loop_patterns.txt");
         abort_run();
      end
      while (!$feof(fd)) begin
         line = "";
         rc   = $fgets(line, fd);
         if (rc > 0 && line.len() > 1 && line.getc(0) != "#") begin
            rc = $sscanf(line, "%s %s %h %h %h %h", name, kind, dst, dat, src, expv);
            if (rc != 6) begin
               $display("Pattern line %0d has %0d of 6 columns", n_lines + 1, rc);
               abort_run();
            end
            req.srcaddr  = src;
            req.data     = dat;
            req.dstaddr  = dst;
            req.ctrlmode = 4'(n_lines);                   // Varies so the copy is visible
            req.datamode = 2'b10;                         // Word access
            req.access   = 1'b1;
            if (kind == "W") begin
               req.write = 1'b1;
            end else if (kind == "R") begin
               req.write = 1'b0;
            end else if (kind == "F") begin
               req.write = expv[0];                       // Filtered write or read
            end else begin
               $display("Pattern line %0d has unknown kind %s", n_lines + 1, kind);
               abort_run();
            end
            pkt.fields = req;
            req_pkts.push_back(pkt);
            if (kind == "R") begin
               rsp         = req;                         // Keeps ctrlmode, datamode
               rsp.dstaddr = req.srcaddr;                 // Back to requester
               rsp.srcaddr = req.dstaddr;
               rsp.data    = expv;
               rsp.write   = 1'b1;
               rsp.access  = 1'b1;
               pkt.fields  = rsp;
               exp_pkts.push_back(pkt);
               exp_names.push_back(name);
            end
            n_lines++;
         end
      end
      $fclose(fd);
   endtask

   // Request driver, valid stays high across back-to-back packets
   always @(posedge clkin) begin
      if (!reset) begin
         if (ext_valid && ext_ready) begin
            sent_cnt <= sent_cnt + 1;
            if (sent_cnt + 1 < n_lines) begin
               ext_packet <= req_pkts[sent_cnt + 1];      // Next one right away
            end else begin
               ext_valid <= 1'b0;                         // List done
            end
         end else if (!ext_valid && sent_cnt < n_lines) begin
            ext_valid  <= 1'b1;
            ext_packet <= req_pkts[sent_cnt];
         end
      end
   end

   // Random back-pressure on the response port
   always @(posedge clkin) begin
      rng_next  = lcg_next(rng_state);
      rng_state <= rng_next;
      dut_ready <= (rng_next[31:28] < 4'd10);             // High about 5 of 8 cycles
   end

   // Response monitor, in-order compare
   always @(posedge clkin) begin
      if (!reset && dut_valid && dut_ready) begin
         if (rsp_cnt < exp_pkts.size()) begin
            check_packet(exp_names[rsp_cnt], exp_pkts[rsp_cnt], dut_packet);
         end
         rsp_cnt <= rsp_cnt + 1;                          // Extra ones show in final count
      end
   end

   // Watchdog
   always @(posedge clkin) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("Timeout after %0d cycles, %0d of %0d requests sent, %0d of %0d responses",
                  cycle_cnt, sent_cnt, n_lines, rsp_cnt, exp_pkts.size());
         abort_run();
      end
   end

   initial begin
      reset      = 1'b1;
      ext_valid  = 1'b0;
      ext_packet = '0;
      dut_ready  = 1'b0;
      sent_cnt   = 0;
      rsp_cnt    = 0;
      cycle_cnt  = 0;
      n_lines    = 0;
      rng_state  = SEED;
      rng_next   = SEED;
      read_patterns();
      cycle_limit = CYCLES_PER_LINE * n_lines + TIMEOUT_MARGIN;
      repeat (RESET_CYCLES) @(posedge clkin);
      reset <= 1'b0;
      while (sent_cnt < n_lines || rsp_cnt < exp_pkts.size()) begin
         @(posedge clkin);
      end
      repeat (DRAIN_CYCLES) @(posedge clkin);            // Filtered reads must stay silent
      check_count("responses_received", exp_pkts.size(), rsp_cnt);
      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire
